// File: intr_ctl.f
+incdir+src
src/intr_event_pkg.sv
src/intr_host_pkg.sv
src/intr_ram.sv
src/alarm_rearm_seq.sv
src/intr_engine.sv
src/intr_ctl_top.sv
verification/intr_ctl_assert.sv
verification/intr_checker.sv
verification/intr_ctl_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the intr_ctl testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f intr_ctl.f \
  --top-module intr_ctl_tb \
  -o Vintr_ctl_tb

./obj_dir/Vintr_ctl_tb | tee "$LOG"

if grep -q "Done: errors found" "$LOG"; then
  echo "Simulation FAILED"
  exit 1
fi

if ! grep -q "Done: no errors" "$LOG"; then
  echo "Simulation ended without a result line"
  exit 1
fi

echo "Simulation PASSED"

// File: verification/intr_ctl_tb.sv
`timescale 1ns/10ps
`include "intr_config.svh"

module intr_ctl_tb;

  import intr_event_pkg::*;
  import intr_host_pkg::*;

  localparam int N_EV     = 150;
  localparam int N_TRAF   = 40;
  localparam int HOST_MAX = 12;            // Worst cycles per host op
  localparam int N_HOST   = 96 + 96 + 8 + 36 + 48 + 64 + N_TRAF;
  localparam int CYCLES   = N_HOST * HOST_MAX + (N_EV + N_TRAF) * 7 + 300 + 200;
  localparam int WATCH_NS = (CYCLES + 2000) * 4;

  logic        iclk;
  logic        reset;
  logic        alarm_restart;
  logic        check_en;
  intr_event_t ev_in;
  host_req_t   host;
  logic        host_rdy;
  logic [`INTR_UP_W-1:0] host_rdata;
  logic        irq;

  int unsigned lcg_state = 49;
  int          tb_errs = 0;
  int          total;

  intr_ctl_top dut_i (
    .iclk          (iclk),
    .reset         (reset),
    .alarm_restart (alarm_restart),
    .ev_in         (ev_in),
    .host          (host),
    .host_rdy      (host_rdy),
    .host_rdata    (host_rdata),
    .irq           (irq)
  );

  intr_checker chk_i (.*);

  initial
  begin
    iclk = 1'b0;
    forever #2 iclk = ~iclk;
  end

  // Watchdog
  initial
  begin
    #(WATCH_NS);
    $display("Timeout: run went past its time budget");
    $display("Done: errors found");
    $finish;
  end

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Drivers

  // One cycle strobe and the next one gap cycles later
  task automatic send_event(intr_event_t ev, int gap);
    @(posedge iclk);
    ev_in <= ev;
    @(posedge iclk);
    ev_in <= '0;
    repeat (gap - 2) @(posedge iclk);
  endtask

  task automatic host_access(logic wr, host_addr_u a, logic [`INTR_UP_W-1:0] wd);
    host_req_t r;
    int        n;
    r       = '0;
    r.en    = 1'b1;
    r.wr    = wr;
    r.rd    = ~wr;
    r.addr  = a;
    r.wdata = wd;
    @(posedge iclk);
    host <= r;
    @(posedge iclk);
    host <= '0;
    n = 0;
    while (!host_rdy && n < 100)
    begin
      @(posedge iclk);
      n++;
    end
    if (!host_rdy)
    begin
      tb_errs++;
      $display("host_rdy never came for address %h", a);
    end
  endtask

  task automatic chan_access(logic wr, host_area_e ar, int c, logic [`INTR_UP_W-1:0] wd);
    host_addr_u a;
    a           = '0;
    a.ch.area   = ar;
    a.ch.seg    = c[`INTR_CH_BITS-1:`INTR_BIT_BITS];
    a.ch.bit_id = c[`INTR_BIT_BITS-1:0];
    host_access(wr, a, wd);
  endtask

  task automatic seg_read(int s);
    host_addr_u a;
    a         = '0;
    a.sg.area = AREA_SEG;
    a.sg.seg  = s[`INTR_SEG_BITS-1:0];
    host_access(1'b0, a, '0);
  endtask

  task automatic read_all_chans();
    for (int c = 0; c < `INTR_CH_NUM; c++)
    begin
      chan_access(1'b0, AREA_STY, c, '0);
      chan_access(1'b0, AREA_STA, c, '0);
      chan_access(1'b0, AREA_EN, c, '0);
    end
  endtask

  function automatic intr_event_t rand_event(int nseg);
    intr_event_t ev;
    ev           = '0;
    ev.valid     = 1'b1;
    ev.seg       = (lcg_next() % nseg);
    ev.bit_id    = lcg_next();
    ev.sty_req   = ((lcg_next() % 4) == 0) ? lcg_next() : '0;   // Rare direct sets
    ev.sta       = lcg_next();
    ev.sta_msk   = lcg_next();
    ev.sta_chgen = lcg_next();
    ev.type_en   = lcg_next();
    return ev;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Test phases

  initial
  begin
    intr_event_t ev;
    reset         = 1'b1;
    alarm_restart = 1'b0;
    check_en      = 1'b0;
    ev_in         = '0;
    host          = '0;
    repeat (4) @(posedge iclk);
    reset <= 1'b0;

    // RAMs have no reset so every word is cleared through the host
    for (int c = 0; c < `INTR_CH_NUM; c++)
    begin
      chan_access(1'b1, AREA_EN, c, '0);
      chan_access(1'b1, AREA_STA, c, '0);
      chan_access(1'b1, AREA_STY, c, 16'h000f);
    end
    check_en <= 1'b1;

    // Random events and read back
    for (int i = 0; i < N_EV; i++)
    begin
      send_event(rand_event(4), 4 + int'(lcg_next() % 4));
    end
    repeat (10) @(posedge iclk);
    read_all_chans();

    // Change detection on channel 5 with bit 0 enabled and bit 1 not
    chan_access(1'b1, AREA_STY, 5, 16'h000f);
    ev           = '0;
    ev.valid     = 1'b1;
    ev.bit_id    = 3'd5;
    ev.sta_msk   = 4'hf;
    send_event(ev, 6);
    ev.sta       = 4'b0011;
    ev.sta_msk   = 4'b0011;
    ev.sta_chgen = 4'b0001;
    send_event(ev, 8);
    chan_access(1'b0, AREA_STY, 5, '0);
    chan_access(1'b0, AREA_STA, 5, '0);

    // Enables, segment words and irq
    for (int c = 0; c < `INTR_CH_NUM; c++)
    begin
      chan_access(1'b1, AREA_EN, c, lcg_next() % 16);
    end
    for (int s = 0; s < `INTR_SEG_NUM; s++)
    begin
      seg_read(s);
    end
    repeat (10) @(posedge iclk);   // Quiet stretch for the irq compare

    // Partial sticky clears and then a full clear
    for (int c = 0; c < `INTR_CH_NUM; c += 2)
    begin
      chan_access(1'b1, AREA_STY, c, lcg_next() % 16);
      chan_access(1'b0, AREA_STY, c, '0);
    end
    for (int c = 0; c < `INTR_CH_NUM; c++)
    begin
      chan_access(1'b1, AREA_STY, c, 16'h000f);
    end
    repeat (10) @(posedge iclk);
    if (irq !== 1'b0)
    begin
      tb_errs++;
      $display("Mismatch at %0t: irq still high after every sticky was cleared", $time);
    end

    // Alarm sweep re-arms stickies from status
    check_en <= 1'b0;
    @(posedge iclk);
    alarm_restart <= 1'b1;
    repeat (3 + 256 + 12) @(posedge iclk);
    alarm_restart <= 1'b0;
    repeat (4) @(posedge iclk);
    check_en <= 1'b1;
    read_all_chans();
    for (int s = 0; s < `INTR_SEG_NUM; s++)
    begin
      seg_read(s);
    end

    // Host reads of segment 3 during event traffic on segments 0 to 2
    fork
      for (int i = 0; i < N_TRAF; i++)
      begin
        send_event(rand_event(3), 4 + int'(lcg_next() % 4));
      end
      for (int i = 0; i < N_TRAF; i++)
      begin
        chan_access(1'b0, AREA_STA, 24 + (i % 8), '0);
      end
    join
    repeat (20) @(posedge iclk);

    chk_i.final_check();
    total = chk_i.mism_cnt + chk_i.proto_cnt + tb_errs;
    $display("Error counts: mismatches %0d, protocol %0d, testbench %0d",
             chk_i.mism_cnt, chk_i.proto_cnt, tb_errs);
    if (total == 0)
    begin
      $display("Done: no errors");
    end
    else
    begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: verification/intr_checker.sv
`timescale 1ns/10ps
`include "intr_config.svh"

module intr_checker (
  input logic                        iclk,
  input logic                        reset,
  input logic                        check_en,     // irq compare allowed
  input logic                        alarm_restart,
  input intr_event_pkg::intr_event_t ev_in,
  input intr_host_pkg::host_req_t    host,
  input logic                        host_rdy,
  input logic [`INTR_UP_W-1:0]       host_rdata,
  input logic                        irq
);

  import intr_event_pkg::*;
  import intr_host_pkg::*;

  // Model of every channel and its segment bit
  logic [`INTR_STY_W-1:0] m_sty [`INTR_CH_NUM];
  logic [`INTR_STA_W-1:0] m_sta [`INTR_CH_NUM];
  logic [`INTR_STY_W-1:0] m_en  [`INTR_CH_NUM];
  logic                   m_seg [`INTR_CH_NUM];

  int        mism_cnt = 0;
  int        proto_cnt = 0;
  int        quiet = 0;      // Cycles since last activity
  logic      alarm_q = 1'b0;
  logic      pend = 1'b0;
  host_req_t req_q;

  initial
  begin
    for (int c = 0; c < `INTR_CH_NUM; c++)
    begin
      m_sty[c] = '0;
      m_sta[c] = '0;
      m_en[c]  = '0;
      m_seg[c] = 1'b0;
    end
  end

  function automatic int chan_of(host_req_t r);
    return int'({r.addr.ch.seg, r.addr.ch.bit_id});
  endfunction

  function automatic logic [`INTR_UP_W-1:0] expect_read(host_req_t r);
    logic [`INTR_UP_W-1:0] v;
    int                    c;
    v = '0;
    c = chan_of(r);
    case (r.addr.ch.area)
      AREA_STY: v[`INTR_STY_W-1:0] = m_sty[c];
      AREA_STA: v[`INTR_STA_W-1:0] = m_sta[c];
      AREA_EN:  v[`INTR_STY_W-1:0] = m_en[c];
      default:
      begin
        for (int b = 0; b < `INTR_BIT_NUM; b++)
        begin
          v[b] = m_seg[int'(r.addr.sg.seg) * `INTR_BIT_NUM + b];
        end
      end
    endcase
    return v;
  endfunction

  function automatic logic model_irq();
    logic any;
    any = 1'b0;
    for (int c = 0; c < `INTR_CH_NUM; c++)
    begin
      any = any | m_seg[c];
    end
    return any;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Model updates, inputs sampled as the DUT sees them

  always @(posedge iclk)
  begin
    logic [`INTR_STA_W-1:0] nsta;
    int                     c;
    if (!reset)
    begin
      quiet = (quiet < 1000) ? quiet + 1 : quiet;
      alarm_q <= alarm_restart;
      if (alarm_restart && !alarm_q)
      begin
        // Sweep re-arms every sticky from its status
        for (int k = 0; k < `INTR_CH_NUM; k++)
        begin
          m_sty[k] = m_sty[k] | m_sta[k];
          m_seg[k] = |(m_sty[k] & m_en[k]);
        end
      end
      if (ev_in.valid)
      begin
        quiet = 0;
        c = int'({ev_in.seg, ev_in.bit_id});
        nsta = (m_sta[c] & ~ev_in.sta_msk) | (ev_in.sta & ev_in.sta_msk);
        m_sty[c] = m_sty[c] | ev_in.sty_req | ((nsta ^ m_sta[c]) & ev_in.sta_chgen);
        m_sta[c] = nsta;
        m_seg[c] = |(m_sty[c] & m_en[c] & ev_in.type_en);
      end
      if (host.en)
      begin
        quiet = 0;
        if (pend)
        begin
          proto_cnt++;
          $display("Host strobe at %0t while a request was still open", $time);
        end
        pend  = 1'b1;
        req_q = host;
        c = chan_of(host);
        if (host.wr && host.addr.ch.area != AREA_SEG)
        begin
          case (host.addr.ch.area)
            AREA_STY: m_sty[c] = m_sty[c] & ~host.wdata[`INTR_STY_W-1:0];
            AREA_STA: m_sta[c] = host.wdata[`INTR_STA_W-1:0];
            default:  m_en[c]  = host.wdata[`INTR_STY_W-1:0];
          endcase
          m_seg[c] = |(m_sty[c] & m_en[c]);   // Host writes count every type
        end
      end
      if (host_rdy)
      begin
        quiet = 0;
        if (!pend)
        begin
          proto_cnt++;
          $display("host_rdy at %0t with no open request", $time);
        end
        else if (req_q.rd && host_rdata !== expect_read(req_q))
        begin
          mism_cnt++;
          $display("Mismatch at %0t: read area %0d addr %h got %h expected %h", $time,
                   req_q.addr.ch.area, req_q.addr, host_rdata, expect_read(req_q));
        end
        pend = 1'b0;
      end
      // irq settles a few cycles after the last update
      if (check_en && quiet == 8 && irq !== model_irq())
      begin
        mism_cnt++;
        $display("Mismatch at %0t: irq is %b expected %b", $time, irq, model_irq());
      end
    end
  end

  task automatic final_check();
    if (pend)
    begin
      proto_cnt++;
      $display("Host request still open at end of run");
    end
  endtask

endmodule

// File: verification/intr_ctl_assert.sv
`timescale 1ns/10ps

module intr_ctl_assert (
  input logic iclk,
  input logic reset,
  input logic ev_valid,   // Event into the engine
  input logic host_en,
  input logic host_rdy
);

  logic req_open;   // Host request not yet answered

  always_ff @(posedge iclk)
  begin
    if (reset)
    begin
      req_open <= 1'b0;
    end
    else if (host_en)
    begin
      req_open <= 1'b1;
    end
    else if (host_rdy)
    begin
      req_open <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Event spacing

  // Sweep sends CLEAR, SET_STK and the next PREREAD back to back
  no_long_run: assert property (@(posedge iclk) disable iff (reset)
    !(ev_valid && $past(ev_valid) && $past(ev_valid, 2) && $past(ev_valid, 3)))
    else $error("four event strobes in a row reached the engine");

  // Three idle cycles at least once a run of strobes ends
  gap_after_run: assert property (@(posedge iclk) disable iff (reset)
    ($past(ev_valid) && !ev_valid) |-> ##1 !ev_valid ##1 !ev_valid)
    else $error("event strobe too soon after the previous one");

  ////////////////////////////////////////////////////////////////////////////
  // Host handshake

  rdy_needs_request: assert property (@(posedge iclk) disable iff (reset)
    host_rdy |-> req_open)
    else $error("host_rdy without an open host request");

  rdy_is_pulse: assert property (@(posedge iclk) disable iff (reset)
    host_rdy |=> !host_rdy)
    else $error("host_rdy held longer than one cycle");

endmodule

bind intr_engine intr_ctl_assert assert_i (
  .iclk     (iclk),
  .reset    (reset),
  .ev_valid (ev_eng.valid),
  .host_en  (host.en),
  .host_rdy (host_rdy)
);

// File: src/intr_ctl_top.sv
`timescale 1ns/10ps
`include "intr_config.svh"

module intr_ctl_top (
  input  logic                        iclk,
  input  logic                        reset,
  input  logic                        alarm_restart,
  input  intr_event_pkg::intr_event_t ev_in,
  input  intr_host_pkg::host_req_t    host,
  output logic                        host_rdy,
  output logic [`INTR_UP_W-1:0]       host_rdata,
  output logic                        irq
);

  import intr_event_pkg::*;

  intr_event_t               ev_eng;       // Sequencer to engine
  logic                      chan_we;
  logic [`INTR_CH_BITS-1:0]  chan_wa;
  chan_word_t                chan_wd;
  logic [`INTR_CH_BITS-1:0]  chan_ra;
  chan_word_t                chan_rdata;   // Also tapped by the sequencer
  logic                      seg_we;
  logic [`INTR_SEG_BITS-1:0] seg_wa;
  logic [`INTR_BIT_NUM-1:0]  seg_wd;
  logic [`INTR_SEG_BITS-1:0] seg_ra;
  logic [`INTR_BIT_NUM-1:0]  seg_rd;

  alarm_rearm_seq seq_i (
    .iclk          (iclk),
    .reset         (reset),
    .alarm_restart (alarm_restart),
    .ev_in         (ev_in),
    .chan_rdata    (chan_rdata),
    .ev_eng        (ev_eng)
  );

  intr_engine eng_i (
    .iclk       (iclk),
    .reset      (reset),
    .ev_eng     (ev_eng),
    .host       (host),
    .host_rdy   (host_rdy),
    .host_rdata (host_rdata),
    .irq        (irq),
    .chan_we    (chan_we),
    .chan_wa    (chan_wa),
    .chan_wd    (chan_wd),
    .chan_ra    (chan_ra),
    .chan_rdata (chan_rdata),
    .seg_we     (seg_we),
    .seg_wa     (seg_wa),
    .seg_wd     (seg_wd),
    .seg_ra     (seg_ra),
    .seg_rd     (seg_rd)
  );

  // Sticky, status and enables per channel
  intr_ram #(.DEPTH(`INTR_CH_NUM), .WIDTH($bits(chan_word_t))) chan_ram_i (
    .iclk (iclk),
    .we   (chan_we),
    .wa   (chan_wa),
    .wd   (chan_wd),
    .ra   (chan_ra),
    .rd   (chan_rdata)
  );

  // One interrupt OR bit per channel
  intr_ram #(.DEPTH(`INTR_SEG_NUM), .WIDTH(`INTR_BIT_NUM)) seg_ram_i (
    .iclk (iclk),
    .we   (seg_we),
    .wa   (seg_wa),
    .wd   (seg_wd),
    .ra   (seg_ra),
    .rd   (seg_rd)
  );

endmodule

// File: src/intr_engine.sv
`timescale 1ns/10ps
`include "intr_config.svh"

module intr_engine (
  input  logic                        iclk,
  input  logic                        reset,
  input  intr_event_pkg::intr_event_t ev_eng,
  input  intr_host_pkg::host_req_t    host,
  output logic                        host_rdy,
  output logic [`INTR_UP_W-1:0]       host_rdata,
  output logic                        irq,
  output logic                        chan_we,
  output logic [`INTR_CH_BITS-1:0]    chan_wa,
  output intr_event_pkg::chan_word_t  chan_wd,
  output logic [`INTR_CH_BITS-1:0]    chan_ra,
  input  intr_event_pkg::chan_word_t  chan_rdata,
  output logic                        seg_we,
  output logic [`INTR_SEG_BITS-1:0]   seg_wa,
  output logic [`INTR_BIT_NUM-1:0]    seg_wd,
  output logic [`INTR_SEG_BITS-1:0]   seg_ra,
  input  logic [`INTR_BIT_NUM-1:0]    seg_rd
);

  import intr_event_pkg::*;
  import intr_host_pkg::*;

  localparam int LAT = `INTR_RAM_LAT;

  // Stage 0 reads, stage LAT modifies and writes
  intr_event_t               ev_pipe [1:LAT];
  logic [LAT+1:1]            ev_vld;      // Extra stage keeps the read port on the channel
  logic [LAT:1]              hst_vld;
  host_req_t                 host_q;      // Held until host_rdy
  logic                      host_pend;   // Waiting for a free slot
  logic                      host_go;
  logic                      busy;
  logic [`INTR_CH_BITS-1:0]  ra_last;
  logic [`INTR_SEG_BITS-1:0] sra_last;
  logic [`INTR_SEG_NUM-1:0]  seg_nz;      // Segments with any bit set

  intr_event_t               ev_w;
  logic                      ev_op;
  logic                      hst_op;
  logic                      hst_chan_wr;
  host_area_e                area;
  chan_word_t                word_new;
  logic [`INTR_STA_W-1:0]    sta_new;
  logic [`INTR_STY_W-1:0]    chg;
  logic [`INTR_STY_W-1:0]    type_m;
  logic                      seg_bit;
  logic [`INTR_UP_W-1:0]     rdata_mux;

  ////////////////////////////////////////////////////////////////////////////
  // Slot control

  assign busy    = ev_eng.valid | (|ev_vld);
  assign host_go = host_pend & ~busy;     // Host only gets empty slots

  always_ff @(posedge iclk)
  begin
    if (reset)
    begin
      ev_vld    <= '0;
      hst_vld   <= '0;
      host_pend <= 1'b0;
      host_rdy  <= 1'b0;
      ra_last   <= '0;
      sra_last  <= '0;
      seg_nz    <= '0;
      irq       <= 1'b0;
    end
    else
    begin
      ev_vld   <= {ev_vld[LAT:1], ev_eng.valid};
      hst_vld  <= {hst_vld[LAT-1:1], host_go};
      host_rdy <= hst_op;
      if (host.en)
      begin
        host_pend <= 1'b1;
      end
      else if (host_go)
      begin
        host_pend <= 1'b0;
      end
      if (ev_eng.valid || host_go)
      begin
        ra_last  <= chan_ra;              // Read port parks here
        sra_last <= seg_ra;
      end
      if (seg_we)
      begin
        seg_nz[seg_wa] <= |seg_wd;
      end
      irq <= |seg_nz;
    end
  end

  always_ff @(posedge iclk)
  begin
    if (host.en)
    begin
      host_q <= host;
    end
    ev_pipe[1] <= ev_eng;
    for (int i = 2; i <= LAT; i++)
    begin
      ev_pipe[i] <= ev_pipe[i-1];
    end
    if (hst_op)
    begin
      host_rdata <= rdata_mux;
    end
  end

  // Read addresses, event first
  always_comb
  begin
    chan_ra = ra_last;
    seg_ra  = sra_last;
    if (ev_eng.valid)
    begin
      chan_ra = {ev_eng.seg, ev_eng.bit_id};
      seg_ra  = ev_eng.seg;
    end
    else if (host_go)
    begin
      chan_ra = {host_q.addr.ch.seg, host_q.addr.ch.bit_id};
      seg_ra  = (host_q.addr.ch.area == AREA_SEG) ? host_q.addr.sg.seg : host_q.addr.ch.seg;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Modify stage

  assign ev_w        = ev_pipe[LAT];
  assign ev_op       = ev_vld[LAT];
  assign hst_op      = hst_vld[LAT];
  assign area        = host_q.addr.ch.area;
  assign hst_chan_wr = hst_op & host_q.wr & (area != AREA_SEG);   // Segment area ignores writes

  always_comb
  begin
    word_new = chan_rdata;
    sta_new  = chan_rdata.sta;
    chg      = '0;
    type_m   = '1;                         // Host updates count every type
    if (ev_op)
    begin
      sta_new      = (chan_rdata.sta & ~ev_w.sta_msk) | (ev_w.sta & ev_w.sta_msk);
      chg          = (sta_new ^ chan_rdata.sta) & ev_w.sta_chgen;
      word_new.sta = sta_new;
      word_new.sty = chan_rdata.sty | ev_w.sty_req | chg;
      type_m       = ev_w.type_en;
    end
    else
    begin
      case (area)
        AREA_STY: word_new.sty    = chan_rdata.sty & ~host_q.wdata[`INTR_STY_W-1:0];
        AREA_STA: word_new.sta    = host_q.wdata[`INTR_STA_W-1:0];
        AREA_EN:  word_new.int_en = host_q.wdata[`INTR_STY_W-1:0];
        default:  word_new        = chan_rdata;
      endcase
    end
    seg_bit = |(word_new.sty & word_new.int_en & type_m);
  end

  assign chan_we = ev_op | hst_chan_wr;
  assign seg_we  = chan_we;
  assign chan_wd = word_new;
  assign chan_wa = ev_op ? {ev_w.seg, ev_w.bit_id} : {host_q.addr.ch.seg, host_q.addr.ch.bit_id};
  assign seg_wa  = chan_wa[`INTR_CH_BITS-1:`INTR_BIT_BITS];

  // Only this channel's bit changes in the segment word
  always_comb
  begin
    seg_wd                               = seg_rd;
    seg_wd[chan_wa[`INTR_BIT_BITS-1:0]] = seg_bit;
  end

  // Host read data, old word on writes
  always_comb
  begin
    rdata_mux = '0;
    case (area)
      AREA_STY: rdata_mux[`INTR_STY_W-1:0]   = chan_rdata.sty;
      AREA_STA: rdata_mux[`INTR_STA_W-1:0]   = chan_rdata.sta;
      AREA_EN:  rdata_mux[`INTR_STY_W-1:0]   = chan_rdata.int_en;
      default:  rdata_mux[`INTR_BIT_NUM-1:0] = seg_rd;
    endcase
  end

endmodule

// File: src/alarm_rearm_seq.sv
`timescale 1ns/10ps
`include "intr_config.svh"

module alarm_rearm_seq (
  input  logic                        iclk,
  input  logic                        reset,
  input  logic                        alarm_restart,
  input  intr_event_pkg::intr_event_t ev_in,
  input  intr_event_pkg::chan_word_t  chan_rdata,
  output intr_event_pkg::intr_event_t ev_eng
);

  import intr_event_pkg::*;

  // Eight states per channel
  typedef enum logic [3:0] {
    IDLE,
    PREREAD,    // Read current word
    WAIT1,
    WAIT2,
    WAIT3,
    WAIT4,
    WAIT5,
    CLEAR,      // Status to zero
    SET_STK     // Old status back, stickies follow
  } seq_state_e;

  seq_state_e               state;
  logic [2:0]               alrm_sr;     // Alarm input shift
  logic                     alrm_rise;
  logic [`INTR_CH_BITS-1:0] ch_cnt;      // Channel under sweep
  logic [`INTR_STA_W-1:0]   sta_lat;     // Status seen by PREREAD
  intr_event_t              ev_nxt;
  intr_event_t              ev_pay;      // Registered event fields
  logic                     ev_vld;      // Registered strobe

  ////////////////////////////////////////////////////////////////////////////
  // Alarm restart edge

  always_ff @(posedge iclk)
  begin
    if (reset)
    begin
      alrm_sr <= '0;
    end
    else
    begin
      alrm_sr <= {alrm_sr[1:0], alarm_restart};
    end
  end

  assign alrm_rise = alrm_sr[1] & ~alrm_sr[2];

  ////////////////////////////////////////////////////////////////////////////
  // Sweep FSM

  always_ff @(posedge iclk)
  begin
    if (reset)
    begin
      state  <= IDLE;
      ch_cnt <= '0;
      ev_vld <= 1'b0;
    end
    else
    begin
      ev_vld <= ev_nxt.valid;
      case (state)
        IDLE:    state <= alrm_rise ? PREREAD : IDLE;
        PREREAD: state <= WAIT1;
        WAIT1:   state <= WAIT2;
        WAIT2:   state <= WAIT3;
        WAIT3:   state <= WAIT4;
        WAIT4:   state <= WAIT5;
        WAIT5:   state <= CLEAR;
        CLEAR:   state <= SET_STK;
        SET_STK:
        begin
          ch_cnt <= ch_cnt + 1'b1;
          state  <= (&ch_cnt) ? IDLE : PREREAD;   // Last channel ends the sweep
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Status of the swept channel is back on the read port by CLEAR
  always_ff @(posedge iclk)
  begin
    if (state == CLEAR)
    begin
      sta_lat <= chan_rdata.sta;
    end
  end

  // Next event, outside events only pass while idle
  always_comb
  begin
    ev_nxt           = '0;
    ev_nxt.seg       = ch_cnt[`INTR_CH_BITS-1:`INTR_BIT_BITS];
    ev_nxt.bit_id    = ch_cnt[`INTR_BIT_BITS-1:0];
    ev_nxt.sta_chgen = '1;
    ev_nxt.type_en   = '1;
    case (state)
      IDLE:    ev_nxt = ev_in;
      PREREAD: ev_nxt.valid = 1'b1;       // Mask zero, word stays as is
      CLEAR:
      begin
        ev_nxt.valid   = 1'b1;
        ev_nxt.sta_msk = '1;              // sta is zero here
      end
      SET_STK:
      begin
        ev_nxt.valid   = 1'b1;
        ev_nxt.sta_msk = '1;
        ev_nxt.sta     = sta_lat;         // Zero to one sets the sticky
      end
      default: ev_nxt.valid = 1'b0;       // Waits
    endcase
  end

  always_ff @(posedge iclk)
  begin
    ev_pay <= ev_nxt;
  end

  always_comb
  begin
    ev_eng       = ev_pay;
    ev_eng.valid = ev_vld;
  end

endmodule

// File: src/intr_ram.sv
`timescale 1ns/10ps

module intr_ram #(
  parameter int DEPTH = 32,
  parameter int WIDTH = 12
) (
  input  logic                     iclk,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] wa,
  input  logic [WIDTH-1:0]         wd,
  input  logic [$clog2(DEPTH)-1:0] ra,
  output logic [WIDTH-1:0]         rd
);

  logic [WIDTH-1:0]         mem [DEPTH];
  logic [$clog2(DEPTH)-1:0] ra_q;   // Registered read address

  always_ff @(posedge iclk)
  begin
    if (we)
    begin
      mem[wa] <= wd;
    end
  end

  // Output register, write data passes straight through on a same address hit
  always_ff @(posedge iclk)
  begin
    ra_q <= ra;
    if (we && (wa == ra_q))
    begin
      rd <= wd;
    end
    else
    begin
      rd <= mem[ra_q];
    end
  end

endmodule

// File: src/intr_host_pkg.sv
`include "intr_config.svh"

package intr_host_pkg;

  // Top two address bits pick the area
  typedef enum logic [1:0] {
    AREA_STY = 2'd0,   // Sticky, write one to clear
    AREA_STA = 2'd1,   // Status
    AREA_EN  = 2'd2,   // Interrupt enables
    AREA_SEG = 2'd3    // Segment OR words, read only
  } host_area_e;

  // Channel areas
  typedef struct packed {
    host_area_e                area;
    logic [`INTR_SEG_BITS-1:0] seg;
    logic [`INTR_BIT_BITS-1:0] bit_id;
  } host_chan_addr_t;

  // Segment area, segment id moves to the bottom
  typedef struct packed {
    host_area_e                area;
    logic [`INTR_BIT_BITS-1:0] spare;   // Ignored
    logic [`INTR_SEG_BITS-1:0] seg;
  } host_seg_addr_t;

  typedef union packed {
    host_chan_addr_t ch;
    host_seg_addr_t  sg;
  } host_addr_u;

  typedef struct packed {
    logic                  en;      // Single cycle strobe
    logic                  wr;
    logic                  rd;
    host_addr_u            addr;
    logic [`INTR_UP_W-1:0] wdata;
  } host_req_t;

endpackage

// File: src/intr_event_pkg.sv
`include "intr_config.svh"

package intr_event_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Channel RAM word

  // Sticky sits in the low bits, enables on top
  typedef struct packed {
    logic [`INTR_STY_W-1:0] int_en;   // Per type interrupt enable
    logic [`INTR_STA_W-1:0] sta;      // Current status
    logic [`INTR_STY_W-1:0] sty;      // Sticky, host clears by writing ones
  } chan_word_t;

  ////////////////////////////////////////////////////////////////////////////
  // Channel event

  // One strobe updates one channel
  typedef struct packed {
    logic                      valid;      // Single cycle strobe
    logic [`INTR_SEG_BITS-1:0] seg;        // Segment id
    logic [`INTR_BIT_BITS-1:0] bit_id;     // Channel inside the segment
    logic [`INTR_STY_W-1:0]    sty_req;    // Direct sticky set
    logic [`INTR_STA_W-1:0]    sta;        // New status value
    logic [`INTR_STA_W-1:0]    sta_msk;    // Status bits taken from sta
    logic [`INTR_CHE_W-1:0]    sta_chgen;  // Changed status bit sets its sticky
    logic [`INTR_STY_W-1:0]    type_en;    // Types allowed into the segment OR
  } intr_event_t;

endpackage

// File: src/intr_config.svh
`ifndef INTR_CONFIG_SVH
`define INTR_CONFIG_SVH

// Channel address is {segment id, bit id}
`define INTR_SEG_BITS 2                                   // 4 segments
`define INTR_BIT_BITS 3                                   // 8 channels per segment
`define INTR_CH_BITS  (`INTR_SEG_BITS + `INTR_BIT_BITS)
`define INTR_SEG_NUM  (1 << `INTR_SEG_BITS)
`define INTR_BIT_NUM  (1 << `INTR_BIT_BITS)               // Also the segment word width
`define INTR_CH_NUM   (1 << `INTR_CH_BITS)

// Per channel fields
// Status bit i pairs with sticky bit i and change enable i
`define INTR_STY_W 4
`define INTR_STA_W 4
`define INTR_CHE_W 4

`define INTR_UP_W    16   // Host data bus
`define INTR_RAM_LAT 2    // Address reg plus output reg

`endif
